/* common/vgc_pkg.sv */
package vgc_pkg;

    // Horizontal raster positions, in pixel ticks
    // Last H count of a line
    localparam logic [9:0] H_LINE_END  = 10'h38F;
    // SCB address goes out for the coming line
    localparam logic [9:0] H_SCB_ADDR  = 10'h38C;
    // SCB byte comes back from memory
    localparam logic [9:0] H_SCB_LATCH = 10'h38E;
    // Palette bytes arrive during H 0..31
    localparam logic [9:0] H_PAL_END   = 10'd32;
    localparam logic [9:0] H_ACT_START = 10'd32;
    // First H count past the 640-tick window
    localparam logic [9:0] H_ACT_END   = 10'd672;

    // Vertical raster positions, in lines
    localparam logic [8:0] V_ACT_START = 9'd32;
    localparam logic [8:0] V_ACT_LINES = 9'd200;
    // Start of vertical blank
    localparam logic [8:0] VBL_LINE    = 9'd232;

    // Video memory address, bank E1 style map
    typedef logic [22:0] vid_addr_t;

    localparam vid_addr_t   ADDR_PIXELS    = 23'h12000;
    localparam int unsigned BYTES_PER_LINE = 160;
    // One SCB byte per line
    localparam vid_addr_t   ADDR_SCB       = 23'h19D00;
    // 16 palettes of 32 bytes each
    localparam vid_addr_t   ADDR_PAL       = 23'h19E00;

    // 4 bits per gun, as stored in the palette
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb4_t;

    // Decoded scanline control byte
    typedef struct packed {
        logic mode_640;  // bit 7
        logic fill;      // bit 5, 320 mode only
        logic irq_en;    // bit 6
    } scb_mode_t;

    // One palette byte on its way to the buffer
    typedef struct packed {
        logic       en;
        logic [3:0] index;
        logic       red_byte;  // odd byte of the entry
        logic [7:0] data;
    } pal_wr_t;

    // Pixel byte stream from fetch to decode
    typedef struct packed {
        logic       active;
        logic       load;  // new byte on data this tick
        scb_mode_t  mode;
        logic [7:0] data;
    } pix_byte_t;

    // Fixed IIgs color set used for the border
    localparam rgb4_t BORDER_PALETTE [0:15] = '{
        12'h000, 12'hD03, 12'h009, 12'hD2D,
        12'h072, 12'h555, 12'h22F, 12'h6AF,
        12'h850, 12'hF60, 12'hAAA, 12'hF98,
        12'h1D0, 12'hFF0, 12'h4F9, 12'hFFF
    };

endpackage

/* shrg/shrg_fetch.sv */
`timescale 1ns/1ps

module shrg_fetch
    import vgc_pkg::*;
(
    input  logic       clk_vid,
    input  logic       arst_n,
    input  logic       ce_pix,
    input  logic [9:0] H,
    input  logic [8:0] V,
    input  logic       shr_enable,
    input  logic [7:0] video_data,
    output vid_addr_t  video_addr,
    output pal_wr_t    pal_wr,
    output pix_byte_t  pix,
    output logic       scanline_irq,
    output logic       vbl_irq
);

    // Line and window decode
    logic [8:0] next_v;
    logic [8:0] row;
    logic       line_act;
    logic       next_line_act;
    logic       h_act;
    logic       v_vbl;

    // Addresses loaded at fixed points of the line
    vid_addr_t  scb_addr;
    vid_addr_t  pal_base;
    vid_addr_t  pix_base;

    // Sequencer state
    scb_mode_t  scb_q;
    logic       pal_odd;
    logic [1:0] phase;
    logic       act_q;
    logic       load_q;
    logic       vbl_d;

    assign next_v        = V + 9'd1;
    assign row           = V - V_ACT_START;
    assign line_act      = (V >= V_ACT_START) && (V < V_ACT_START + V_ACT_LINES);
    assign next_line_act = (next_v >= V_ACT_START) && (next_v < V_ACT_START + V_ACT_LINES);
    assign h_act         = (H >= H_ACT_START) && (H < H_ACT_END);
    assign v_vbl         = (V == VBL_LINE);

    // SCB belongs to the line after this one
    assign scb_addr = ADDR_SCB + vid_addr_t'(next_v - V_ACT_START);
    // Palette number is the SCB low nibble, 32 bytes per palette
    assign pal_base = ADDR_PAL + vid_addr_t'({video_data[3:0], 5'b00000});
    assign pix_base = ADDR_PIXELS + vid_addr_t'(row) * vid_addr_t'(BYTES_PER_LINE);

    always_ff @(posedge clk_vid or negedge arst_n) begin
        if (!arst_n) begin
            video_addr   <= '0;
            scb_q        <= '0;
            pal_odd      <= 1'b0;
            phase        <= 2'd0;
            act_q        <= 1'b0;
            load_q       <= 1'b0;
            scanline_irq <= 1'b0;
            vbl_d        <= 1'b0;
            vbl_irq      <= 1'b0;
        end else if (ce_pix) begin
            // Stream flags lag H by one tick
            act_q  <= shr_enable && line_act && h_act;
            load_q <= shr_enable && line_act && h_act && (phase == 2'd0);

            // One tick pulse on entry to the VBL line
            vbl_d   <= v_vbl;
            vbl_irq <= v_vbl && !vbl_d;

            if (H == H_SCB_ADDR) begin
                video_addr <= scb_addr;
            end else if (H == H_SCB_LATCH) begin
                scb_q <= '{mode_640: video_data[7], fill: video_data[5],
                           irq_en: video_data[6]};
                video_addr <= pal_base;
                pal_odd    <= 1'b0;
                if (video_data[6] && shr_enable && next_line_act) begin
                    scanline_irq <= 1'b1;
                end
            end else if (H == H_LINE_END) begin
                // Second palette byte goes out so data runs back to back from H=0
                video_addr <= video_addr + 23'd1;
            end else if (H < H_PAL_END) begin
                pal_odd <= !pal_odd;
                if (H == H_PAL_END - 10'd1) begin
                    // Pixel byte 0 must be on the bus during H=32
                    video_addr <= pix_base;
                    phase      <= 2'd0;
                end else begin
                    video_addr <= video_addr + 23'd1;
                end
            end else if (h_act) begin
                phase <= phase + 2'd1;
                // Four ticks per byte, next address ready one tick early
                if (phase == 2'd3) begin
                    video_addr <= video_addr + 23'd1;
                end
            end

            // IRQ spans the last tick of the line and H=0
            if (H == 10'd0) begin
                scanline_irq <= 1'b0;
            end
        end
    end

    // Palette bytes go straight to the buffer as they return
    always_comb begin
        pal_wr.en       = ce_pix && (H < H_PAL_END);
        pal_wr.index    = H[4:1];
        pal_wr.red_byte = pal_odd;
        pal_wr.data     = video_data;
    end

    // Pixel data is taken live off the bus, flags are registered
    always_comb begin
        pix.active = act_q;
        pix.load   = load_q;
        pix.mode   = scb_q;
        pix.data   = video_data;
    end

endmodule

/* shrg/shrg_palette.sv */
`timescale 1ns/1ps

module shrg_palette
    import vgc_pkg::*;
(
    input  logic       clk_vid,
    input  logic       arst_n,
    input  pal_wr_t    pal_wr,
    input  logic [3:0] rd_index,
    output rgb4_t      rd_color
);

    // Palette of the line being displayed
    rgb4_t pal_q [0:15];

    always_ff @(posedge clk_vid or negedge arst_n) begin
        if (!arst_n) begin
            // Black until the first line loads its palette
            for (int i = 0; i < 16; i++) begin
                pal_q[i] <= '0;
            end
        end else if (pal_wr.en) begin
            if (pal_wr.red_byte) begin
                // Odd byte, red in the low nibble
                pal_q[pal_wr.index].red <= pal_wr.data[3:0];
            end else begin
                // Even byte carries green and blue
                pal_q[pal_wr.index].green <= pal_wr.data[7:4];
                pal_q[pal_wr.index].blue  <= pal_wr.data[3:0];
            end
        end
    end

    // Read port is combinational
    assign rd_color = pal_q[rd_index];

endmodule

/* shrg/shrg_pixel.sv */
`timescale 1ns/1ps

module shrg_pixel
    import vgc_pkg::*;
(
    input  logic       clk_vid,
    input  logic       arst_n,
    input  logic       ce_pix,
    input  pix_byte_t  pix,
    input  logic [3:0] border_color,
    output logic [3:0] rd_index,
    input  rgb4_t      rd_color,
    output logic [7:0] R,
    output logic [7:0] G,
    output logic [7:0] B
);

    // Held pixel byte and position within it
    logic [7:0] byte_q;
    logic [1:0] slot_q;
    // Last nonzero index for fill mode
    logic [3:0] last_q;

    logic [7:0] cur_byte;
    logic [1:0] slot;
    logic [3:0] nib;
    logic [3:0] idx;
    rgb4_t      border_rgb;
    rgb4_t      out_rgb;

    // A fresh byte is used on the tick it arrives
    assign cur_byte = pix.load ? pix.data : byte_q;
    assign slot     = pix.load ? 2'd0 : slot_q;

    // 320 mode shows each nibble for two ticks
    assign nib = slot[1] ? cur_byte[3:0] : cur_byte[7:4];

    always_comb begin
        if (pix.mode.mode_640) begin
            // Each 2-bit pixel picks from its own group of four
            case (slot)
                2'd0:    idx = {2'b10, cur_byte[7:6]};
                2'd1:    idx = {2'b11, cur_byte[5:4]};
                2'd2:    idx = {2'b00, cur_byte[3:2]};
                default: idx = {2'b01, cur_byte[1:0]};
            endcase
        end else if (pix.mode.fill && (nib == 4'd0)) begin
            idx = last_q;
        end else begin
            idx = nib;
        end
    end

    assign rd_index = idx;

    assign border_rgb = BORDER_PALETTE[border_color];
    assign out_rgb    = pix.active ? rd_color : border_rgb;

    // Pixel byte held for the rest of its four ticks
    always_ff @(posedge clk_vid) begin
        if (ce_pix && pix.load) begin
            byte_q <= pix.data;
        end
    end

    always_ff @(posedge clk_vid or negedge arst_n) begin
        if (!arst_n) begin
            slot_q <= 2'd0;
            last_q <= 4'd0;
            R      <= 8'd0;
            G      <= 8'd0;
            B      <= 8'd0;
        end else if (ce_pix) begin
            slot_q <= slot + 2'd1;

            // Fill history starts over on every line
            if (!pix.active) begin
                last_q <= 4'd0;
            end else if (!pix.mode.mode_640 && (nib != 4'd0)) begin
                last_q <= nib;
            end

            // Nibble doubled out to 8 bits per gun
            R <= {out_rgb.red, out_rgb.red};
            G <= {out_rgb.green, out_rgb.green};
            B <= {out_rgb.blue, out_rgb.blue};
        end
    end

endmodule

/* hw/vgc_top.sv */
`timescale 1ns/1ps

module vgc_top
    import vgc_pkg::*;
(
    input  logic       clk_vid,
    input  logic       arst_n,
    input  logic       ce_pix,
    input  logic [9:0] H,
    input  logic [8:0] V,
    input  logic       shr_enable,
    input  logic [3:0] border_color,
    input  logic [7:0] video_data,
    output vid_addr_t  video_addr,
    output logic [7:0] R,
    output logic [7:0] G,
    output logic [7:0] B,
    output logic       scanline_irq,
    output logic       vbl_irq
);

    pal_wr_t    pal_wr;
    pix_byte_t  pix;
    logic [3:0] rd_index;
    rgb4_t      rd_color;

    // Memory sequencer for SCB, palette and pixel bytes
    shrg_fetch i_fetch (
        .clk_vid      (clk_vid),
        .arst_n       (arst_n),
        .ce_pix       (ce_pix),
        .H            (H),
        .V            (V),
        .shr_enable   (shr_enable),
        .video_data   (video_data),
        .video_addr   (video_addr),
        .pal_wr       (pal_wr),
        .pix          (pix),
        .scanline_irq (scanline_irq),
        .vbl_irq      (vbl_irq)
    );

    // Per-line palette
    shrg_palette i_palette (
        .clk_vid  (clk_vid),
        .arst_n   (arst_n),
        .pal_wr   (pal_wr),
        .rd_index (rd_index),
        .rd_color (rd_color)
    );

    // Pixel decode and RGB output
    shrg_pixel i_pixel (
        .clk_vid      (clk_vid),
        .arst_n       (arst_n),
        .ce_pix       (ce_pix),
        .pix          (pix),
        .border_color (border_color),
        .rd_index     (rd_index),
        .rd_color     (rd_color),
        .R            (R),
        .G            (G),
        .B            (B)
    );

endmodule

/* sim/vgc_properties.sv */
`timescale 1ns/1ps

module vgc_properties
    import vgc_pkg::*;
(
    input logic       clk_vid,
    input logic       arst_n,
    input logic       ce_pix,
    input logic [9:0] H,
    input logic [8:0] V,
    input logic       shr_enable,
    input logic [3:0] border_color,
    input logic [7:0] R,
    input logic [7:0] G,
    input logic [7:0] B,
    input logic       scanline_irq,
    input logic       vbl_irq,
    input logic       irq_line_en
);

    // Border flag and color delayed to line up with the RGB pipeline
    logic        bd1;
    logic        bd2;
    logic [3:0]  bc1;
    logic        vbl_prev;
    int unsigned vbl_cnt;
    int unsigned prop_errors = 0;
    logic        in_window;
    rgb4_t       exp_border;

    assign in_window  = shr_enable && (V >= V_ACT_START) && (V < V_ACT_START + V_ACT_LINES)
                        && (H >= H_ACT_START) && (H < H_ACT_END);
    assign exp_border = BORDER_PALETTE[bc1];

    always_ff @(posedge clk_vid or negedge arst_n) begin
        if (!arst_n) begin
            bd1      <= 1'b0;
            bd2      <= 1'b0;
            bc1      <= 4'd0;
            vbl_prev <= 1'b0;
            vbl_cnt  <= 0;
        end else if (ce_pix) begin
            bd1      <= !in_window;
            bd2      <= bd1;
            bc1      <= border_color;
            vbl_prev <= vbl_irq;
            // Pulse count starts over with each frame
            if ((H == 10'd0) && (V == 9'd0)) begin
                vbl_cnt <= 0;
            end else if (vbl_irq) begin
                vbl_cnt <= vbl_cnt + 1;
            end
        end
    end

    a_border: assert property (@(posedge clk_vid) disable iff (!arst_n)
        ce_pix && bd2 |-> (R == {exp_border.red, exp_border.red})
            && (G == {exp_border.green, exp_border.green})
            && (B == {exp_border.blue, exp_border.blue}))
        else begin
            prop_errors++;
            $error("[ERROR] %0t RGB border expected %h got %h %h %h", $time, exp_border, R, G, B);
        end

    // Both nibbles of every gun match
    a_nibbles: assert property (@(posedge clk_vid) disable iff (!arst_n)
        (R[7:4] == R[3:0]) && (G[7:4] == G[3:0]) && (B[7:4] == B[3:0]))
        else begin
            prop_errors++;
            $error("[ERROR] %0t RGB nibbles differ, got %h %h %h", $time, R, G, B);
        end

    a_irq_line: assert property (@(posedge clk_vid) disable iff (!arst_n)
        ce_pix && scanline_irq |-> irq_line_en)
        else begin
            prop_errors++;
            $error("[ERROR] %0t scanline_irq expected 0 got 1", $time);
        end

    a_irq_set: assert property (@(posedge clk_vid) disable iff (!arst_n)
        ce_pix && (H == H_LINE_END) && irq_line_en |-> scanline_irq)
        else begin
            prop_errors++;
            $error("[ERROR] %0t scanline_irq expected 1 got 0", $time);
        end

    a_vbl_line: assert property (@(posedge clk_vid) disable iff (!arst_n)
        ce_pix && vbl_irq |-> (V == VBL_LINE) && !vbl_prev)
        else begin
            prop_errors++;
            $error("[ERROR] %0t vbl_irq expected 0 got 1", $time);
        end

    a_vbl_once: assert property (@(posedge clk_vid) disable iff (!arst_n)
        ce_pix && (H == 10'd0) && (V == VBL_LINE + 9'd1) |-> (vbl_cnt == 1))
        else begin
            prop_errors++;
            $error("[ERROR] %0t vbl_irq pulse count expected 1 got %0d", $time, vbl_cnt);
        end

endmodule

/* sim/tb_vgc.sv */
`timescale 1ns/1ps

module tb_vgc
    import vgc_pkg::*;
;

    localparam int ROW_320  = 10;
    localparam int ROW_FILL = 60;
    localparam int ROW_640  = 120;
    // Model array offsets relative to ADDR_PIXELS
    localparam int OFF_SCB  = 32'h7D00;
    localparam int OFF_PAL  = 32'h7E00;
    localparam int FRAME_TICKS = 912 * 262;
    // Two clocks of 40 ns per tick, three frames and some margin
    localparam longint WATCHDOG_NS = longint'(3 * FRAME_TICKS + 20000) * 80;

    logic       clk_vid;
    logic       arst_n;
    logic       ce_pix;
    logic [9:0] H;
    logic [8:0] V;
    logic       shr_enable;
    logic [3:0] border_color;
    logic [7:0] video_data;
    vid_addr_t  video_addr;
    logic [7:0] R;
    logic [7:0] G;
    logic [7:0] B;
    logic       scanline_irq;
    logic       vbl_irq;

    logic [7:0]  mem [0:32767];
    logic [31:0] lfsr_state;
    logic        irq_line_en;
    int          frame_cnt = 0;
    int          errors = 0;
    int          checks_320 = 0;
    int          checks_fill = 0;
    int          checks_640 = 0;

    vgc_top i_dut (
        .clk_vid      (clk_vid),
        .arst_n       (arst_n),
        .ce_pix       (ce_pix),
        .H            (H),
        .V            (V),
        .shr_enable   (shr_enable),
        .border_color (border_color),
        .video_data   (video_data),
        .video_addr   (video_addr),
        .R            (R),
        .G            (G),
        .B            (B),
        .scanline_irq (scanline_irq),
        .vbl_irq      (vbl_irq)
    );

    bind vgc_top vgc_properties i_props (
        .clk_vid (clk_vid), .arst_n (arst_n), .ce_pix (ce_pix), .H (H), .V (V),
        .shr_enable (shr_enable), .border_color (border_color),
        .R (R), .G (G), .B (B), .scanline_irq (scanline_irq), .vbl_irq (vbl_irq),
        .irq_line_en (tb_vgc.irq_line_en)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'hA3000000 : 32'h0);
    endfunction

    // One LFSR step per bit
    task automatic next_byte(output logic [7:0] b);
        b = 8'h00;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [7:0] mem_read(input vid_addr_t a);
        vid_addr_t off;
        off = a - ADDR_PIXELS;
        if ((a >= ADDR_PIXELS) && (off < 23'h8000)) begin
            return mem[off[14:0]];
        end
        return 8'h00;
    endfunction

    task automatic set_line(input int row, input logic [7:0] scb, input logic [7:0] pix_byte);
        mem[OFF_SCB + row] = scb;
        for (int i = 0; i < 160; i++) begin
            mem[row * 160 + i] = pix_byte;
        end
    endtask

    // Palette color of a pixel slot, from the SCB and the model palette bytes
    function automatic rgb4_t expected_color(input logic [7:0] scb, input logic [7:0] b,
                                             input logic [1:0] slot);
        logic [3:0] nib;
        logic [3:0] other;
        logic [3:0] idx;
        int         off;
        rgb4_t      c;
        nib   = slot[1] ? b[3:0] : b[7:4];
        other = slot[1] ? b[7:4] : b[3:0];
        if (scb[7]) begin
            // Groups 8, 12, 0, 4 for fields 7:6, 5:4, 3:2, 1:0
            idx = {~slot[1], slot[0], 2'b00};
            idx = idx | {2'b00, b[7 - 2 * slot -: 2]};
        end else if (scb[5] && (nib == 4'd0)) begin
            idx = other;
        end else begin
            idx = nib;
        end
        off     = OFF_PAL + 32 * int'(scb[3:0]) + 2 * int'(idx);
        c.green = mem[off][7:4];
        c.blue  = mem[off][3:0];
        c.red   = mem[off + 1][3:0];
        return c;
    endfunction

    task automatic report_error(input string name, input logic [7:0] exp, input logic [7:0] act);
        errors++;
        $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
    endtask

    task automatic check_pixel(input int row);
        logic [9:0] hs;
        rgb4_t      c;
        hs = H - 10'd34;
        c  = expected_color(mem[OFF_SCB + row], mem[row * 160], hs[1:0]);
        assert (R == {c.red, c.red}) else report_error("R", {c.red, c.red}, R);
        assert (G == {c.green, c.green}) else report_error("G", {c.green, c.green}, G);
        assert (B == {c.blue, c.blue}) else report_error("B", {c.blue, c.blue}, B);
    endtask

    // SCB interrupt bit of the line the pending IRQ belongs to
    always_comb begin
        logic [8:0] nv;
        logic [8:0] row;
        nv  = (H == 10'd0) ? V : V + 9'd1;
        row = nv - V_ACT_START;
        irq_line_en = shr_enable && (nv >= V_ACT_START) && (nv < V_ACT_START + V_ACT_LINES)
                      && mem[OFF_SCB + int'(row)][6];
    end

    initial begin
        clk_vid = 1'b0;
        forever #20 clk_vid = ~clk_vid;
    end

    // Raster counters advance once per tick
    always @(posedge clk_vid) begin
        if (arst_n) begin
            ce_pix <= !ce_pix;
            if (ce_pix) begin
                if (H == H_LINE_END) begin
                    H <= 10'd0;
                    if (V == 9'd261) begin
                        V            <= 9'd0;
                        frame_cnt    <= frame_cnt + 1;
                        // Third frame runs with SHR off
                        shr_enable   <= (frame_cnt < 1);
                        border_color <= border_color + 4'd5;
                    end else begin
                        V <= V + 9'd1;
                    end
                end else begin
                    H <= H + 10'd1;
                end
            end
        end
    end

    // Memory answers one tick after the address
    always @(posedge clk_vid) begin
        if (ce_pix) begin
            video_data <= mem_read(video_addr);
        end
    end

    // Middle of each test line
    always @(posedge clk_vid) begin
        if (arst_n && ce_pix && shr_enable && (H >= 10'd100) && (H < 10'd600)) begin
            if (V == V_ACT_START + 9'(ROW_320)) begin
                check_pixel(ROW_320);
                checks_320++;
            end else if (V == V_ACT_START + 9'(ROW_FILL)) begin
                check_pixel(ROW_FILL);
                checks_fill++;
            end else if (V == V_ACT_START + 9'(ROW_640)) begin
                check_pixel(ROW_640);
                checks_640++;
            end
        end
    end

    initial begin
        logic [7:0] b;
        arst_n       = 1'b0;
        ce_pix       = 1'b0;
        H            = 10'd0;
        V            = 9'd0;
        shr_enable   = 1'b1;
        border_color = 4'd6;
        video_data   = 8'h00;
        lfsr_state   = 32'h9364;
        for (int i = 0; i < 32768; i++) begin
            next_byte(b);
            mem[i] = b;
        end
        // 320 with IRQ, 320 with fill, 640
        set_line(ROW_320, 8'h43, 8'h5A);
        set_line(ROW_FILL, 8'h25, 8'h70);
        set_line(ROW_640, 8'h89, 8'hE4);
        repeat (8) @(posedge clk_vid);
        arst_n <= 1'b1;
        wait (frame_cnt == 3);
        if ((checks_320 == 0) || (checks_fill == 0) || (checks_640 == 0)) begin
            errors++;
            $display("Pixel checks never ran on one of the test lines");
        end
        $display("errors: %0d testbench, %0d assertions", errors, i_dut.i_props.prop_errors);
        if ((errors == 0) && (i_dut.i_props.prop_errors == 0)) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before three frames completed");
        $display("tests failed");
        $finish;
    end

endmodule

/* sources.f */
common/vgc_pkg.sv
shrg/shrg_fetch.sv
shrg/shrg_palette.sv
shrg/shrg_pixel.sv
hw/vgc_top.sv
sim/vgc_properties.sv
sim/tb_vgc.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_vgc
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed

.PHONY: sim clean

# Build, run and look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
